// ==== design/gray_pkg.sv ====
package gray_pkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------
    localparam int COLOR_W      = 10;
    localparam int FRAME_PIXELS = 169;
    localparam int PIX_IDX_W    = 8;
    localparam int FIFO_DEPTH   = 8;
    localparam int LEVEL_W      = 4;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

    // Product of a channel and the widest weight (seven bits) before the shift.
    localparam int PROD_W = COLOR_W + 7;

    // ----------------------------------------
    // Luma weights, as fractions weight / 2**shift
    // ----------------------------------------
    localparam int WEIGHT_R = 19;
    localparam int SHIFT_R  = 6;
    localparam int WEIGHT_G = 75;
    localparam int SHIFT_G  = 7;
    localparam int WEIGHT_B = 37;
    localparam int SHIFT_B  = 8;

    localparam int BW_THRESHOLD = 125;
    localparam int BW_WHITE     = 255;

    // ----------------------------------------
    // Pixel types
    // ----------------------------------------
    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } rgb_t;

    typedef struct packed {
        rgb_t pix;
        logic last;
    } tagged_pix_t;

    typedef struct packed {
        logic [COLOR_W-1:0] luma;
        logic [COLOR_W-1:0] bw;
    } gray_t;

endpackage

// ==== design/frame_fetch.sv ====
`timescale 1ns/1ps

module frame_fetch import gray_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic [LEVEL_W-1:0]   i_fifo_level,

    output logic                 o_rd_req,
    output logic [PIX_IDX_W-1:0] o_rd_idx,
    input  logic                 i_rd_valid,
    input  rgb_t                 i_rd_data,

    output logic                 o_wr,
    output tagged_pix_t          o_wr_data
);

    typedef enum logic {
        S_IDLE,
        S_FETCH
    } state_e;

    state_e               state_r, state_w;
    logic [PIX_IDX_W-1:0] req_idx_r, req_idx_w;
    logic [PIX_IDX_W-1:0] ret_cnt_r, ret_cnt_w;
    logic [LEVEL_W-1:0]   outst_r, outst_w;
    logic                 wr_r;
    tagged_pix_t          wr_data_r;

    logic [LEVEL_W:0]     used;
    logic                 req;
    logic                 ret_last;

    assign o_rd_req  = req;
    assign o_rd_idx  = req_idx_r;
    assign o_wr      = wr_r;
    assign o_wr_data = wr_data_r;

    // Entries already committed: stored, in flight at the memory, or about
    // to be written from the return register.
    assign used = {1'b0, i_fifo_level} + {1'b0, outst_r} + {{LEVEL_W{1'b0}}, wr_r};

    assign req = (state_r == S_FETCH)
              && (req_idx_r < PIX_IDX_W'(FRAME_PIXELS))
              && (used < (LEVEL_W+1)'(FIFO_DEPTH));

    assign ret_last = (ret_cnt_r == PIX_IDX_W'(FRAME_PIXELS - 1));

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_w   = state_r;
        req_idx_w = req_idx_r;
        ret_cnt_w = ret_cnt_r;
        outst_w   = outst_r;

        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w   = S_FETCH;
                    req_idx_w = '0;
                    ret_cnt_w = '0;
                    outst_w   = '0;
                end
            end
            S_FETCH: begin
                if (req) begin
                    req_idx_w = req_idx_r + 1'b1;
                end
                if (i_rd_valid) begin
                    ret_cnt_w = ret_cnt_r + 1'b1;
                end
                case ({req, i_rd_valid})
                    2'b10:   outst_w = outst_r + 1'b1;
                    2'b01:   outst_w = outst_r - 1'b1;
                    default: outst_w = outst_r;
                endcase
                // The frame ends once the tagged last pixel is in the FIFO.
                if (wr_r && wr_data_r.last) begin
                    state_w = S_IDLE;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r   <= S_IDLE;
            req_idx_r <= '0;
            ret_cnt_r <= '0;
            outst_r   <= '0;
            wr_r      <= 1'b0;
        end else begin
            state_r   <= state_w;
            req_idx_r <= req_idx_w;
            ret_cnt_r <= ret_cnt_w;
            outst_r   <= outst_w;
            wr_r      <= (state_r == S_FETCH) && i_rd_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd_valid) begin
            wr_data_r.pix  <= i_rd_data;
            wr_data_r.last <= ret_last;
        end
    end

endmodule

// ==== design/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo import gray_pkg::*; #(
    parameter type T = logic
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_wr,
    input  T                   i_wr_data,
    input  logic               i_rd,
    output T                   o_rd_data,
    output logic               o_empty,
    output logic [LEVEL_W-1:0] o_level
);

    T                        mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]   wr_ptr_r;
    logic [FIFO_PTR_W-1:0]   rd_ptr_r;
    logic [LEVEL_W-1:0]      level_r;

    logic                    do_wr;
    logic                    do_rd;

    // Writes into a full FIFO and reads from an empty one are dropped.
    assign do_wr = i_wr && (level_r != LEVEL_W'(FIFO_DEPTH));
    assign do_rd = i_rd && (level_r != '0);

    assign o_rd_data = mem[rd_ptr_r];
    assign o_empty   = (level_r == '0);
    assign o_level   = level_r;

    // ----------------------------------------
    // Pointers and level
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            level_r  <= '0;
        end else begin
            // The depth is a power of two so both pointers wrap on their own.
            if (do_wr) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   level_r <= level_r + 1'b1;
                2'b01:   level_r <= level_r - 1'b1;
                default: level_r <= level_r;
            endcase
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr_r] <= i_wr_data;
        end
    end

endmodule

// ==== design/gray_convert.sv ====
`timescale 1ns/1ps

module gray_convert import gray_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_slot,
    input  logic        i_empty,
    input  tagged_pix_t i_head,

    output logic        o_rd,
    output logic        o_gray_valid,
    output gray_t       o_gray,
    output logic        o_underrun,
    output logic        o_frame_done
);

    logic [PROD_W-1:0]  prod_red;
    logic [PROD_W-1:0]  prod_green;
    logic [PROD_W-1:0]  prod_blue;

    // Stage one.
    logic               s1_valid_r;
    logic               s1_under_r;
    logic               s1_last_r;
    logic [COLOR_W-1:0] s1_red_r;
    logic [COLOR_W-1:0] s1_green_r;
    logic [COLOR_W-1:0] s1_blue_r;

    logic [COLOR_W-1:0] luma;

    assign o_rd = i_slot && !i_empty;

    assign prod_red   = PROD_W'(i_head.pix.red)   * PROD_W'(WEIGHT_R);
    assign prod_green = PROD_W'(i_head.pix.green) * PROD_W'(WEIGHT_G);
    assign prod_blue  = PROD_W'(i_head.pix.blue)  * PROD_W'(WEIGHT_B);

    // The sum wraps at ten bits, like each truncated product.
    assign luma = s1_red_r + s1_green_r + s1_blue_r;

    // ----------------------------------------
    // Strobes through both stages
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid_r   <= 1'b0;
            s1_under_r   <= 1'b0;
            s1_last_r    <= 1'b0;
            o_gray_valid <= 1'b0;
            o_underrun   <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            s1_valid_r   <= o_rd;
            s1_under_r   <= i_slot && i_empty;
            s1_last_r    <= o_rd && i_head.last;
            o_gray_valid <= s1_valid_r;
            o_underrun   <= s1_under_r;
            o_frame_done <= s1_valid_r && s1_last_r;
        end
    end

    // ----------------------------------------
    // Data path
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (o_rd) begin
            s1_red_r   <= COLOR_W'(prod_red >> SHIFT_R);
            s1_green_r <= COLOR_W'(prod_green >> SHIFT_G);
            s1_blue_r  <= COLOR_W'(prod_blue >> SHIFT_B);
        end
        if (s1_valid_r) begin
            o_gray.luma <= luma;
            o_gray.bw   <= (luma > COLOR_W'(BW_THRESHOLD)) ? COLOR_W'(BW_WHITE) : '0;
        end
    end

endmodule

// ==== design/gray_top.sv ====
`timescale 1ns/1ps

module gray_top import gray_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,

    // Pixel memory side.
    output logic                 o_rd_req,
    output logic [PIX_IDX_W-1:0] o_rd_idx,
    input  logic                 i_rd_valid,
    input  rgb_t                 i_rd_data,

    // Display side.
    input  logic                 i_slot,
    output logic                 o_gray_valid,
    output gray_t                o_gray,
    output logic                 o_underrun,
    output logic                 o_frame_done
);

    logic               fifo_wr;
    tagged_pix_t        fifo_wr_data;
    logic               fifo_rd;
    tagged_pix_t        fifo_head;
    logic               fifo_empty;
    logic [LEVEL_W-1:0] fifo_level;

    frame_fetch u_fetch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_fifo_level (fifo_level),
        .o_rd_req     (o_rd_req),
        .o_rd_idx     (o_rd_idx),
        .i_rd_valid   (i_rd_valid),
        .i_rd_data    (i_rd_data),
        .o_wr         (fifo_wr),
        .o_wr_data    (fifo_wr_data)
    );

    pixel_fifo #(
        .T (tagged_pix_t)
    ) u_fifo (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (fifo_wr),
        .i_wr_data (fifo_wr_data),
        .i_rd      (fifo_rd),
        .o_rd_data (fifo_head),
        .o_empty   (fifo_empty),
        .o_level   (fifo_level)
    );

    gray_convert u_convert (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_slot       (i_slot),
        .i_empty      (fifo_empty),
        .i_head       (fifo_head),
        .o_rd         (fifo_rd),
        .o_gray_valid (o_gray_valid),
        .o_gray       (o_gray),
        .o_underrun   (o_underrun),
        .o_frame_done (o_frame_done)
    );

endmodule

// ==== tests/gray_assertions.sv ====
`timescale 1ns/1ps

module gray_assertions import gray_pkg::*; (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_start,
    input logic i_rd_req,
    input logic i_gray_valid,
    input logic i_underrun,
    input logic i_fifo_wr,
    input logic i_fifo_rd
);

    int   fail_count = 0;
    int   model_level;
    logic started_r;

    // Set by the first start after reset.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            started_r <= 1'b0;
        end else if (i_start) begin
            started_r <= 1'b1;
        end
    end

    // Entries written minus entries read, counted from the strobes alone.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            model_level <= 0;
        end else begin
            model_level <= model_level + int'(i_fifo_wr) - int'(i_fifo_rd);
        end
    end

    level_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        model_level <= FIFO_DEPTH)
    else begin
        $error("FIFO level %0d is above the FIFO depth", model_level);
        fail_count++;
    end

    no_empty_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fifo_rd |-> model_level > 0)
    else begin
        $error("FIFO read while empty");
        fail_count++;
    end

    pixel_or_underrun: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_gray_valid && i_underrun))
    else begin
        $error("o_gray_valid and o_underrun high in the same cycle");
        fail_count++;
    end

    quiet_before_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !started_r |-> !i_rd_req)
    else begin
        $error("o_rd_req high before any start");
        fail_count++;
    end

endmodule

// ==== tests/tb_gray_top.sv ====
`timescale 1ns/1ps

module tb_gray_top import gray_pkg::*; ();

    logic                 i_clk = 1'b0;
    logic                 i_rst_n = 1'b0;
    logic                 i_start = 1'b0;
    logic                 o_rd_req;
    logic [PIX_IDX_W-1:0] o_rd_idx;
    logic                 i_rd_valid = 1'b0;
    rgb_t                 i_rd_data = '0;
    logic                 i_slot = 1'b0;
    logic                 o_gray_valid;
    gray_t                o_gray;
    logic                 o_underrun;
    logic                 o_frame_done;

    rgb_t                 pix_mem [FRAME_PIXELS];
    int                   lat_mem [FRAME_PIXELS];
    logic [COLOR_W-1:0]   exp_luma [FRAME_PIXELS];
    logic [COLOR_W-1:0]   exp_bw [FRAME_PIXELS];
    int                   pend_idx [$];
    int                   pend_due [$];

    int     errors = 0;
    int     cycle = 0;
    int     req_total = 0;
    int     out_total = 0;
    int     slot_cnt = 0;
    int     under_cnt = 0;
    int     done_cnt = 0;
    integer seed = 32'h5019a0ba;
    logic   slots_on = 1'b1;
    logic   stim_ok = 1'b1;
    // Two frames are fetched.
    int     timeout_limit = 40 * 2 * FRAME_PIXELS + 200;

    gray_top DUT (.*);

    bind gray_top gray_assertions u_assertions (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_rd_req     (o_rd_req),
        .i_gray_valid (o_gray_valid),
        .i_underrun   (o_underrun),
        .i_fifo_wr    (fifo_wr),
        .i_fifo_rd    (fifo_rd)
    );

    always #10 i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_stimulus();
        int                 fd;
        int                 r;
        int                 file_count;
        int                 lat;
        string              line;
        logic [COLOR_W-1:0] rr, gg, bb, luma, bw;
        fd = $fopen("tests/gray_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the data file tests/gray_stimulus.txt");
            stim_ok = 1'b0;
        end else begin
            r = $fgets(line, fd);
            while (r > 0 && line.substr(0, 0) == "#") begin
                r = $fgets(line, fd);
            end
            r = $sscanf(line, "%d", file_count);
            check_value("pixel count in data file", FRAME_PIXELS, file_count);
            for (int i = 0; i < FRAME_PIXELS; i++) begin
                r = $fscanf(fd, "%h %h %h %h %h %h", rr, gg, bb, lat, luma, bw);
                if (r != 6) begin
                    $display("The data file ends early, at pixel %0d", i);
                    errors++;
                    break;
                end
                pix_mem[i]  = '{red: rr, green: gg, blue: bb};
                lat_mem[i]  = lat;
                exp_luma[i] = luma;
                exp_bw[i]   = bw;
            end
            $fclose(fd);
        end
    endtask

    task automatic pulse_start();
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
    endtask

    // ----------------------------------------
    // Pixel memory, in-order answers
    // ----------------------------------------
    always @(posedge i_clk) begin
        i_rd_valid <= 1'b0;
        if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
            i_rd_valid <= 1'b1;
            i_rd_data  <= pix_mem[pend_idx[0]];
            void'(pend_idx.pop_front());
            void'(pend_due.pop_front());
        end
        if (o_rd_req && o_rd_idx < FRAME_PIXELS) begin
            pend_idx.push_back(o_rd_idx);
            pend_due.push_back(cycle + lat_mem[o_rd_idx]);
        end
    end

    // Display slots, never two in a row.
    always @(posedge i_clk) begin
        if (!i_rst_n || !slots_on || i_slot) begin
            i_slot <= 1'b0;
        end else begin
            i_slot <= ($random(seed) & 1) != 0;
        end
    end

    // ----------------------------------------
    // Output monitor
    // ----------------------------------------
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            if (o_rd_req) begin
                check_value("o_rd_idx", req_total % FRAME_PIXELS, o_rd_idx);
                req_total++;
            end
            if (i_slot) begin
                slot_cnt++;
            end
            if (o_underrun) begin
                under_cnt++;
            end
            if (o_gray_valid) begin
                if (out_total == 0) begin
                    // The first pixel comes back late, so the early slots underrun.
                    check_value("o_underrun seen before first pixel", 1, under_cnt > 0);
                end
                check_value("o_gray.luma", exp_luma[out_total % FRAME_PIXELS], o_gray.luma);
                check_value("o_gray.bw", exp_bw[out_total % FRAME_PIXELS], o_gray.bw);
                out_total++;
            end
            if (o_frame_done) begin
                done_cnt++;
                check_value("o_gray_valid at o_frame_done", 1, o_gray_valid);
                check_value("pixels out at o_frame_done", done_cnt * FRAME_PIXELS, out_total);
            end
        end
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle == timeout_limit) begin
            $display("Timeout: the frames did not finish within %0d cycles", timeout_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        load_stimulus();
        if (!stim_ok) begin
            $display("Checks failed");
        end else begin
            repeat (5) @(posedge i_clk);
            i_rst_n <= 1'b1;
            repeat (2) @(posedge i_clk);
            pulse_start();
            // A start in the middle of the frame must not restart the fetch.
            while (req_total < 20) @(posedge i_clk);
            pulse_start();
            while (done_cnt < 1) @(posedge i_clk);
            check_value("o_rd_req count after frame 1", FRAME_PIXELS, req_total);
            repeat (10) @(posedge i_clk);
            pulse_start();
            while (done_cnt < 2) @(posedge i_clk);
            slots_on <= 1'b0;
            repeat (4) @(posedge i_clk);

            check_value("o_frame_done count", 2, done_cnt);
            check_value("o_gray_valid count", 2 * FRAME_PIXELS, out_total);
            check_value("o_rd_req count", 2 * FRAME_PIXELS, req_total);
            check_value("o_gray_valid plus o_underrun count", slot_cnt, out_total + under_cnt);

            $display("Summary: %0d check errors, %0d assertion failures", errors,
                     DUT.u_assertions.fail_count);
            if (errors == 0 && DUT.u_assertions.fail_count == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/gray_pkg.sv
design/frame_fetch.sv
design/pixel_fifo.sv
design/gray_convert.sv
design/gray_top.sv
tests/gray_assertions.sv
tests/tb_gray_top.sv

// ==== Bender.yml ====
package:
  name: gray_stage

sources:
  - design/gray_pkg.sv
  - design/frame_fetch.sv
  - design/pixel_fifo.sv
  - design/gray_convert.sv
  - design/gray_top.sv
  - target: test
    files:
      - tests/gray_assertions.sv
      - tests/tb_gray_top.sv

// ==== tests/gray_stimulus.txt ====
# Pixel count in decimal on the first data line, then six hex fields per pixel:
# red green blue latency luma bw (latency in clock cycles after the request)
169
0 0 0 1E 0 0  3FF 3FF 3FF 2 19 0  100 0 0 3 4C 0  0 100 0 4 96 FF
0 0 100 5 25 0  200 200 200 1 20E FF  80 80 80 2 83 FF  70 70 70 3 72 0
0 D6 0 4 7D 0  0 D8 0 5 7E FF  1A3 C7 2F1 1 15C FF  3F 15 3E8 2 AE FF
11 22 33 3 1F 0  0 0 0 4 0 0  3FF 3FF 3FF 5 19 0  100 0 0 1 4C 0
0 100 0 2 96 FF  0 0 100 3 25 0  200 200 200 4 20E FF  80 80 80 5 83 FF
70 70 70 1 72 0  0 D6 0 2 7D 0  0 D8 0 3 7E FF  1A3 C7 2F1 4 15C FF
3F 15 3E8 5 AE FF  11 22 33 1 1F 0  0 0 0 2 0 0  3FF 3FF 3FF 3 19 0
100 0 0 4 4C 0  0 100 0 5 96 FF  0 0 100 1 25 0  200 200 200 2 20E FF
80 80 80 3 83 FF  70 70 70 4 72 0  0 D6 0 5 7D 0  0 D8 0 1 7E FF
1A3 C7 2F1 2 15C FF  3F 15 3E8 3 AE FF  11 22 33 4 1F 0  0 0 0 5 0 0
3FF 3FF 3FF 1 19 0  100 0 0 2 4C 0  0 100 0 3 96 FF  0 0 100 4 25 0
200 200 200 5 20E FF  80 80 80 1 83 FF  70 70 70 2 72 0  0 D6 0 3 7D 0
0 D8 0 4 7E FF  1A3 C7 2F1 5 15C FF  3F 15 3E8 1 AE FF  11 22 33 2 1F 0
0 0 0 3 0 0  3FF 3FF 3FF 4 19 0  100 0 0 5 4C 0  0 100 0 1 96 FF
0 0 100 2 25 0  200 200 200 3 20E FF  80 80 80 4 83 FF  70 70 70 5 72 0
0 D6 0 1 7D 0  0 D8 0 2 7E FF  1A3 C7 2F1 3 15C FF  3F 15 3E8 4 AE FF
11 22 33 5 1F 0  0 0 0 1 0 0  3FF 3FF 3FF 2 19 0  100 0 0 3 4C 0
0 100 0 4 96 FF  0 0 100 5 25 0  200 200 200 1 20E FF  80 80 80 2 83 FF
70 70 70 3 72 0  0 D6 0 4 7D 0  0 D8 0 5 7E FF  1A3 C7 2F1 1 15C FF
3F 15 3E8 2 AE FF  11 22 33 3 1F 0  0 0 0 4 0 0  3FF 3FF 3FF 5 19 0
100 0 0 1 4C 0  0 100 0 2 96 FF  0 0 100 3 25 0  200 200 200 4 20E FF
80 80 80 14 83 FF  70 70 70 1 72 0  0 D6 0 2 7D 0  0 D8 0 3 7E FF
1A3 C7 2F1 4 15C FF  3F 15 3E8 5 AE FF  11 22 33 1 1F 0  0 0 0 2 0 0
3FF 3FF 3FF 3 19 0  100 0 0 4 4C 0  0 100 0 5 96 FF  0 0 100 1 25 0
200 200 200 2 20E FF  80 80 80 3 83 FF  70 70 70 4 72 0  0 D6 0 5 7D 0
0 D8 0 1 7E FF  1A3 C7 2F1 2 15C FF  3F 15 3E8 3 AE FF  11 22 33 4 1F 0
0 0 0 5 0 0  3FF 3FF 3FF 1 19 0  100 0 0 2 4C 0  0 100 0 3 96 FF
0 0 100 4 25 0  200 200 200 5 20E FF  80 80 80 1 83 FF  70 70 70 2 72 0
0 D6 0 3 7D 0  0 D8 0 4 7E FF  1A3 C7 2F1 5 15C FF  3F 15 3E8 1 AE FF
11 22 33 2 1F 0  0 0 0 3 0 0  3FF 3FF 3FF 4 19 0  100 0 0 5 4C 0
0 100 0 1 96 FF  0 0 100 2 25 0  200 200 200 3 20E FF  80 80 80 4 83 FF
70 70 70 5 72 0  0 D6 0 1 7D 0  0 D8 0 2 7E FF  1A3 C7 2F1 3 15C FF
3F 15 3E8 4 AE FF  11 22 33 5 1F 0  0 0 0 1 0 0  3FF 3FF 3FF 2 19 0
100 0 0 3 4C 0  0 100 0 4 96 FF  0 0 100 5 25 0  200 200 200 1 20E FF
80 80 80 2 83 FF  70 70 70 3 72 0  0 D6 0 4 7D 0  0 D8 0 5 7E FF
1A3 C7 2F1 1 15C FF  3F 15 3E8 2 AE FF  11 22 33 3 1F 0  0 0 0 4 0 0
3FF 3FF 3FF 5 19 0  100 0 0 1 4C 0  0 100 0 2 96 FF  0 0 100 3 25 0
200 200 200 4 20E FF  80 80 80 5 83 FF  70 70 70 1 72 0  0 D6 0 2 7D 0
0 D8 0 3 7E FF  1A3 C7 2F1 4 15C FF  3F 15 3E8 5 AE FF  11 22 33 1 1F 0
0 0 0 2 0 0  3FF 3FF 3FF 3 19 0  100 0 0 4 4C 0  0 100 0 5 96 FF
0 0 100 1 25 0  200 200 200 2 20E FF  80 80 80 3 83 FF  70 70 70 4 72 0
0 D6 0 5 7D 0  0 D8 0 1 7E FF  1A3 C7 2F1 2 15C FF  3F 15 3E8 3 AE FF
11 22 33 4 1F 0
